// File: dv/cpu_tb.sv
/* Memory answers each access after 0 to 2 wait cycles. The program keeps every producer
   at least two instructions ahead of its consumer, since the core has no forwarding. */
`default_nettype none

module cpu_tb import cpu_types_pkg::*; ();

    localparam logic [5:0] OPC_RTYPE    = 6'h00;
    localparam logic [5:0] OPC_BEQ      = 6'h04;
    localparam logic [5:0] OPC_ADDIU    = 6'h09;
    localparam logic [5:0] OPC_LW       = 6'h23;
    localparam logic [5:0] OPC_SW       = 6'h2B;
    localparam logic [5:0] FN_SLL       = 6'h00;
    localparam logic [5:0] FN_ADDU      = 6'h21;
    localparam logic [5:0] FN_SUBU      = 6'h23;
    localparam logic [5:0] FN_AND       = 6'h24;
    localparam logic [5:0] FN_OR        = 6'h25;
    localparam logic [5:0] FN_SLT       = 6'h2A;
    localparam word_t      HALT_WORD    = 32'hFC00_0000;
    localparam word_t      DATA_BASE    = 32'h0000_0100;
    localparam int         HALT_TIMEOUT = 3000;

    logic   CLK         = 1'b0;
    logic   nRST        = 1'b0;
    word_t  mem_rdata_i = '0;
    logic   mem_ready_i = 1'b0;
    word_t  mem_addr_o;
    word_t  mem_wdata_o;
    logic   mem_ren_o;
    logic   mem_wen_o;
    logic   halt_o;

    word_t  mem [256];
    word_t  exp_addr [16];
    word_t  exp_data [16];
    int     n_exp      = 0;
    int     store_idx  = 0;
    int     errors     = 0;
    int     wait_left  = 0;
    int     pc_idx     = 0;
    int     cycles     = 0;
    integer seed       = 32'h5139;
    logic   busy       = 1'b0;
    logic   done_store = 1'b0;

    always #5 CLK = ~CLK;

    pipeline_cpu u_pipeline_cpu (
        .CLK, .nRST, .mem_rdata_i, .mem_ready_i, .mem_addr_o, .mem_wdata_o,
        .mem_ren_o, .mem_wen_o, .halt_o);

    // ============================================================
    // Program image
    // ============================================================
    function automatic word_t rtype_word(logic [5:0] fn, int rd, int rs, int rt, int shamt);
        return {OPC_RTYPE, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t fill_word(int idx);
        return 32'h5A00_0000 ^ (word_t'(idx) * 32'h0001_0103);
    endfunction

    task automatic put_instr(input word_t w);
        mem[pc_idx[7:0]] = w;
        pc_idx = pc_idx + 1;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr[n_exp[3:0]] = addr;
        exp_data[n_exp[3:0]] = data;
        n_exp = n_exp + 1;
    endtask

    task automatic load_program();
        word_t a;
        word_t b;
        a = 32'd7;
        b = 32'hFFFF_FFFD;
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = fill_word(i);
        end
        put_instr(itype_word(OPC_ADDIU, 1, 0, 7));
        put_instr(itype_word(OPC_ADDIU, 2, 0, -3));
        put_instr(itype_word(OPC_ADDIU, 10, 0, 'h100));
        put_instr(32'h0);
        put_instr(rtype_word(FN_ADDU, 3, 1, 2, 0));
        put_instr(rtype_word(FN_SUBU, 4, 1, 2, 0));
        put_instr(rtype_word(FN_AND, 5, 1, 2, 0));
        put_instr(rtype_word(FN_OR, 6, 1, 2, 0));
        put_instr(rtype_word(FN_SLT, 7, 2, 1, 0));
        put_instr(rtype_word(FN_SLL, 8, 0, 1, 4));
        put_instr(itype_word(OPC_ADDIU, 9, 1, -20));
        for (int r = 3; r <= 9; r++) begin
            put_instr(itype_word(OPC_SW, r, 10, (r - 3) * 4));
        end
        put_instr(itype_word(OPC_LW, 11, 10, 64));
        put_instr(32'h0);
        put_instr(32'h0);
        put_instr(itype_word(OPC_SW, 11, 10, 28));
        put_instr(itype_word(OPC_BEQ, 1, 1, 2));    // Taken, skips the next two stores.
        put_instr(itype_word(OPC_SW, 1, 10, 32));
        put_instr(itype_word(OPC_SW, 2, 10, 36));
        put_instr(itype_word(OPC_SW, 4, 10, 44));
        put_instr(itype_word(OPC_BEQ, 2, 1, 1));    // Not taken.
        put_instr(itype_word(OPC_SW, 5, 10, 48));
        put_instr(HALT_WORD);
        put_instr(32'h0);
        put_instr(32'h0);
        put_instr(32'h0);

        expect_store(DATA_BASE, a + b);
        expect_store(DATA_BASE + 4, a - b);
        expect_store(DATA_BASE + 8, a & b);
        expect_store(DATA_BASE + 12, a | b);
        expect_store(DATA_BASE + 16, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expect_store(DATA_BASE + 20, a << 4);
        expect_store(DATA_BASE + 24, a + 32'hFFFF_FFEC);
        expect_store(DATA_BASE + 28, fill_word(int'((DATA_BASE + 64) >> 2)));
        expect_store(DATA_BASE + 44, a - b);
        expect_store(DATA_BASE + 48, a & b);
    endtask

    // ============================================================
    // Memory model
    // ============================================================
    always @(negedge CLK) begin
        mem_ready_i = 1'b0;
        if (done_store) begin
            store_idx  = store_idx + 1;    // The store seen last cycle is retired.
            done_store = 1'b0;
        end
        if (mem_ren_o || mem_wen_o) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $unsigned($random(seed)) % 3;
            end
            if (wait_left == 0) begin
                busy        = 1'b0;
                mem_ready_i = 1'b1;
                mem_rdata_i = mem[mem_addr_o[9:2]];
                if (mem_wen_o) begin
                    mem[mem_addr_o[9:2]] = mem_wdata_o;
                    done_store           = 1'b1;
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // ============================================================
    // Checks
    // ============================================================
    a_store_count: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wen_o && mem_ready_i) |-> store_idx < n_exp)
        else begin
            errors = errors + 1;
            $display("Error at time %0t: store to %h beyond the expected list", $time,
                     mem_addr_o);
        end

    a_store_addr: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wen_o && mem_ready_i && store_idx < n_exp) |->
        mem_addr_o == exp_addr[store_idx[3:0]])
        else begin
            errors = errors + 1;
            $display("Mismatch at time %0t: mem_addr_o got %h expected %h", $time,
                     mem_addr_o, exp_addr[store_idx[3:0]]);
        end

    a_store_data: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wen_o && mem_ready_i && store_idx < n_exp) |->
        mem_wdata_o == exp_data[store_idx[3:0]])
        else begin
            errors = errors + 1;
            $display("Mismatch at time %0t: mem_wdata_o got %h expected %h", $time,
                     mem_wdata_o, exp_data[store_idx[3:0]]);
        end

    a_one_access: assert property (@(posedge CLK) !(mem_ren_o && mem_wen_o))
        else begin
            errors = errors + 1;
            $display("Error at time %0t: read and write requested together", $time);
        end

    a_reset_quiet: assert property (@(posedge CLK)
        (!nRST || $rose(nRST)) |-> !(mem_ren_o || mem_wen_o || halt_o))
        else begin
            errors = errors + 1;
            $display("Error at time %0t: memory request or halt active around reset", $time);
        end

    a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt_o |=> halt_o)
        else begin
            errors = errors + 1;
            $display("Error at time %0t: halt_o dropped after rising", $time);
        end

    a_halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        halt_o |-> !(mem_ren_o || mem_wen_o))
        else begin
            errors = errors + 1;
            $display("Error at time %0t: memory request after halt", $time);
        end

    initial begin
        load_program();
        repeat (4) @(negedge CLK);
        nRST = 1'b1;
        while (!halt_o && cycles < HALT_TIMEOUT) begin
            @(negedge CLK);
            cycles = cycles + 1;
        end
        if (!halt_o) begin
            $display("Timeout: halt_o did not rise within %0d cycles", HALT_TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            repeat (20) @(negedge CLK);    // Let the halt checks watch a quiet bus.
            assert (store_idx == n_exp) else begin
                errors = errors + 1;
                $display("Mismatch at time %0t: store count got %0d expected %0d", $time,
                         store_idx, n_exp);
            end
            $display("Run complete: %0d errors, %0d of %0d stores seen", errors, store_idx,
                     n_exp);
            if (errors == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/memory_arbiter.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/id_ex.sv
logic/execute_mem_stage.sv
logic/hazard_unit.sv
logic/pipeline_cpu.sv
dv/cpu_tb.sv

// File: logic/cpu_macros.svh
/* Core-wide sizes. The register file and word width are fixed at MIPS32 values. */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ============================================================
// Datapath sizing
// ============================================================
`define CPU_WORD_W   32
`define CPU_NUM_REGS 32

// ============================================================
// Reset state
// ============================================================
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: logic/cpu_types_pkg.sv
/* Encodings follow MIPS32 for the supported subset only. HALT is opcode 6'b111111. */
`default_nettype none
`include "cpu_macros.svh"

package cpu_types_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [4:0]             regbits_t;

    // ============================================================
    // Instruction fields
    // ============================================================
    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        BEQ   = 6'b000100,
        ADDIU = 6'b001001,
        LW    = 6'b100011,
        SW    = 6'b101011,
        HALT  = 6'b111111
    } opcode_t;

    typedef enum logic [5:0] {
        SLL  = 6'b000000,
        ADDU = 6'b100001,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        SLT  = 6'b101010
    } funct_t;

    // ALU_SLL doubles as the bubble value.
    typedef enum logic [2:0] {
        ALU_SLL = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_SLT = 3'd5
    } aluop_t;

endpackage

`default_nettype wire

// File: logic/decode_stage.sv
/* Register 0 reads as zero. A write in the same cycle as a read is passed through to it. */
`default_nettype none
`include "cpu_macros.svh"

module decode_stage import cpu_types_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  word_t    instr_i,
    input  word_t    npc_i,
    input  logic     wb_wen_i,
    input  regbits_t wb_sel_i,
    input  word_t    wb_data_i,
    output word_t    rdat1_o,
    output word_t    rdat2_o,
    output word_t    imm_o,
    output regbits_t rd_sel_o,
    output logic     reg_wr_o,
    output logic     alu_src_o,
    output aluop_t   alu_op_o,
    output logic     dren_o,
    output logic     dwen_o,
    output logic     branch_o,
    output logic     halt_o
);
    opcode_t  op;
    funct_t   fn;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    word_t    regs [`CPU_NUM_REGS];

    assign op    = opcode_t'(instr_i[31:26]);
    assign fn    = funct_t'(instr_i[5:0]);
    assign rs    = instr_i[25:21];
    assign rt    = instr_i[20:16];
    assign rd    = instr_i[15:11];
    assign imm_o = {{16{instr_i[15]}}, instr_i[15:0]};

    // ============================================================
    // Control decode
    // ============================================================
    always_comb begin
        rd_sel_o  = rt;
        reg_wr_o  = 1'b0;
        alu_src_o = 1'b0;
        alu_op_o  = ALU_SLL;
        dren_o    = 1'b0;
        dwen_o    = 1'b0;
        branch_o  = 1'b0;
        halt_o    = 1'b0;
        case (op)
            RTYPE: begin
                rd_sel_o = rd;
                reg_wr_o = 1'b1;
                case (fn)
                    SLL:     alu_op_o = ALU_SLL;
                    ADDU:    alu_op_o = ALU_ADD;
                    SUBU:    alu_op_o = ALU_SUB;
                    AND:     alu_op_o = ALU_AND;
                    OR:      alu_op_o = ALU_OR;
                    SLT:     alu_op_o = ALU_SLT;
                    default: reg_wr_o = 1'b0;   // Unsupported funct acts as a no-op.
                endcase
            end
            ADDIU: begin
                reg_wr_o  = 1'b1;
                alu_src_o = 1'b1;
                alu_op_o  = ALU_ADD;
            end
            LW: begin
                reg_wr_o  = 1'b1;
                alu_src_o = 1'b1;
                alu_op_o  = ALU_ADD;
                dren_o    = 1'b1;
            end
            SW: begin
                alu_src_o = 1'b1;
                alu_op_o  = ALU_ADD;
                dwen_o    = 1'b1;
            end
            BEQ: begin
                branch_o = 1'b1;
                alu_op_o = ALU_SUB;
            end
            HALT:    halt_o = 1'b1;
            default: ;
        endcase
    end

    // ============================================================
    // Register file
    // ============================================================
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen_i && wb_sel_i != '0) begin
            regs[wb_sel_i] <= wb_data_i;
        end
    end

    assign rdat1_o = (rs == '0) ? '0 :
                     (wb_wen_i && wb_sel_i == rs) ? wb_data_i : regs[rs];
    assign rdat2_o = (rt == '0) ? '0 :
                     (wb_wen_i && wb_sel_i == rt) ? wb_data_i : regs[rt];

    a_unknown_op: assert property (@(posedge CLK) disable iff (!nRST)
        !(op inside {RTYPE, ADDIU, LW, SW, BEQ, HALT}) |-> !reg_wr_o);
    a_npc_align: assert property (@(posedge CLK) disable iff (!nRST)
        npc_i[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: logic/execute_mem_stage.sv
/* Loads and stores hold their request until dhit. Once halted, nothing younger than the HALT
   reaches memory or the register file. */
`default_nettype none

module execute_mem_stage import cpu_types_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       en_i,
    input  word_t      npc_i, rdat1_i, rdat2_i, imm_i,
    input  logic [4:0] shamt_i,
    input  regbits_t   rd_sel_i,
    input  logic       reg_wr_i, alu_src_i,
    input  aluop_t     alu_op_i,
    input  logic       dren_i, dwen_i, branch_i, halt_i,
    input  logic       dhit_i,
    input  word_t      rdata_i,
    output logic       dren_o,
    output logic       dwen_o,
    output word_t      daddr_o,
    output word_t      dstore_o,
    output logic       branch_taken_o,
    output word_t      branch_target_o,
    output logic       halt_o,
    output logic       wb_wen_o,
    output regbits_t   wb_sel_o,
    output word_t      wb_data_o
);
    word_t opb;
    word_t alu_out;
    logic  halt_q;

    // ============================================================
    // ALU
    // ============================================================
    assign opb = alu_src_i ? imm_i : rdat2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: alu_out = rdat1_i + opb;
            ALU_SUB: alu_out = rdat1_i - opb;
            ALU_AND: alu_out = rdat1_i & opb;
            ALU_OR:  alu_out = rdat1_i | opb;
            ALU_SLT: alu_out = ($signed(rdat1_i) < $signed(opb)) ? word_t'(1) : '0;
            default: alu_out = rdat2_i << shamt_i;   // SLL shifts rt.
        endcase
    end

    assign branch_taken_o  = branch_i & ~halt_q & (rdat1_i == rdat2_i);
    assign branch_target_o = npc_i + {imm_i[29:0], 2'b00};

    // ============================================================
    // Memory access and writeback latch
    // ============================================================
    assign dren_o   = dren_i & ~halt_q;
    assign dwen_o   = dwen_i & ~halt_q;
    assign daddr_o  = alu_out;
    assign dstore_o = rdat2_i;
    assign halt_o   = halt_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halt_q    <= 1'b0;
            wb_wen_o  <= 1'b0;
            wb_sel_o  <= '0;
            wb_data_o <= '0;
        end else begin
            if (halt_i) begin
                halt_q <= 1'b1;   // Sticky until reset.
            end
            if (en_i) begin
                wb_wen_o  <= reg_wr_i & ~halt_q;
                wb_sel_o  <= rd_sel_i;
                wb_data_o <= dren_i ? rdata_i : alu_out;
            end
        end
    end

    a_access_done: assert property (@(posedge CLK) disable iff (!nRST)
        (en_i && (dren_o || dwen_o)) |-> dhit_i);

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
/* One fetch is outstanding at a time. A branch taken during a fetch wait redirects the PC
   once that fetch returns, and the returned word is dropped. */
`default_nettype none
`include "cpu_macros.svh"

module fetch_stage import cpu_types_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  en_i,
    input  logic  flush_i,
    input  logic  halt_i,
    input  logic  branch_taken_i,
    input  word_t branch_target_i,
    input  logic  ihit_i,
    input  word_t rdata_i,
    output logic  iren_o,
    output word_t iaddr_o,
    output word_t instr_o,
    output word_t npc_o,
    output logic  valid_o
);
    word_t pc_q;
    word_t redir_pc_q;
    word_t pc_plus4;
    logic  redir_q;
    logic  run_q;
    logic  take;

    assign pc_plus4 = pc_q + 32'd4;
    assign iren_o   = run_q & ~halt_i;
    assign iaddr_o  = pc_q;
    assign take     = ihit_i & en_i & ~redir_q;   // A word returned while stalled is refetched.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;   // First fetch goes out one cycle after reset release.
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc_q    <= `CPU_RESET_PC;
            redir_q <= 1'b0;
        end else if (branch_taken_i) begin
            if (ihit_i) begin
                pc_q <= branch_target_i;
            end else begin
                redir_q <= 1'b1;   // Keep the pending address steady until it returns.
            end
        end else if (ihit_i && redir_q) begin
            pc_q    <= redir_pc_q;
            redir_q <= 1'b0;
        end else if (take) begin
            pc_q <= pc_plus4;
        end
    end

    always_ff @(posedge CLK) begin
        if (branch_taken_i) begin
            redir_pc_q <= branch_target_i;
        end
    end

    // ============================================================
    // Fetch/decode latch
    // ============================================================
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            instr_o <= '0;
            npc_o   <= '0;
            valid_o <= 1'b0;
        end else if (flush_i) begin
            instr_o <= '0;
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= take;
            if (take) begin
                instr_o <= rdata_i;
                npc_o   <= pc_plus4;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
/* No forwarding and no RAW interlock. Software spaces producers and consumers apart. */
`default_nettype none

module hazard_unit (
    input  logic dren_i,
    input  logic dwen_i,
    input  logic dhit_i,
    input  logic fetch_valid_i,
    input  logic branch_taken_i,
    output logic en_o,
    output logic freeze_o,
    output logic flush_o
);
    logic dwait;

    // ============================================================
    // Pipeline control
    // ============================================================
    assign dwait    = (dren_i | dwen_i) & ~dhit_i;
    assign en_o     = ~dwait;            // Every latch holds while a data access waits.
    assign freeze_o = ~fetch_valid_i;    // Nothing to decode, so a bubble moves on.
    assign flush_o  = branch_taken_i;

endmodule

`default_nettype wire

// File: logic/id_ex.sv
/* Priority is flush, then freeze with en, then en. A bubble carries no writes and ALU_SLL. */
`default_nettype none

module id_ex import cpu_types_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       en_i,
    input  logic       freeze_i,
    input  logic       flush_i,
    input  word_t      npc_i, rdat1_i, rdat2_i, imm_i,
    input  logic [4:0] shamt_i,
    input  regbits_t   rd_sel_i,
    input  logic       reg_wr_i, alu_src_i,
    input  aluop_t     alu_op_i,
    input  logic       dren_i, dwen_i, branch_i, halt_i,
    output word_t      npc_o, rdat1_o, rdat2_o, imm_o,
    output logic [4:0] shamt_o,
    output regbits_t   rd_sel_o,
    output logic       reg_wr_o, alu_src_o,
    output aluop_t     alu_op_o,
    output logic       dren_o, dwen_o, branch_o, halt_o
);
    logic bubble;

    assign bubble = flush_i | (freeze_i & en_i);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            {npc_o, rdat1_o, rdat2_o, imm_o, shamt_o, rd_sel_o} <= '0;
            {reg_wr_o, alu_src_o, dren_o, dwen_o, branch_o, halt_o} <= '0;
            alu_op_o <= ALU_SLL;
        end else if (bubble) begin
            {npc_o, rdat1_o, rdat2_o, imm_o, shamt_o, rd_sel_o} <= '0;
            {reg_wr_o, alu_src_o, dren_o, dwen_o, branch_o, halt_o} <= '0;
            alu_op_o <= ALU_SLL;
        end else if (en_i) begin
            npc_o     <= npc_i;
            rdat1_o   <= rdat1_i;
            rdat2_o   <= rdat2_i;
            imm_o     <= imm_i;
            shamt_o   <= shamt_i;
            rd_sel_o  <= rd_sel_i;
            reg_wr_o  <= reg_wr_i;
            alu_src_o <= alu_src_i;
            alu_op_o  <= alu_op_i;
            dren_o    <= dren_i;
            dwen_o    <= dwen_i;
            branch_o  <= branch_i;
            halt_o    <= halt_i;
        end
    end

    a_flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
        flush_i |=> !(reg_wr_o || dwen_o || halt_o));

endmodule

`default_nettype wire

// File: logic/memory_arbiter.sv
/* Data requests win the single port. An access that has started keeps its side until
   mem_ready_i, as long as its requester still asks. */
`default_nettype none

module memory_arbiter import cpu_types_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  iren_i,
    input  word_t iaddr_i,
    input  logic  dren_i,
    input  logic  dwen_i,
    input  word_t daddr_i,
    input  word_t dstore_i,
    input  word_t mem_rdata_i,
    input  logic  mem_ready_i,
    output logic  ihit_o,
    output logic  dhit_o,
    output word_t rdata_o,
    output word_t mem_addr_o,
    output word_t mem_wdata_o,
    output logic  mem_ren_o,
    output logic  mem_wen_o
);
    logic dreq;
    logic sel_d;
    logic busy_q;
    logic own_d_q;

    assign dreq  = dren_i | dwen_i;
    assign sel_d = (busy_q && (own_d_q ? dreq : iren_i)) ? own_d_q : dreq;

    assign mem_addr_o  = sel_d ? daddr_i : iaddr_i;
    assign mem_wdata_o = dstore_i;
    assign mem_ren_o   = sel_d ? dren_i : iren_i;
    assign mem_wen_o   = sel_d & dwen_i;
    assign ihit_o      = mem_ready_i & ~sel_d & iren_i;
    assign dhit_o      = mem_ready_i & sel_d;
    assign rdata_o     = mem_rdata_i;   // Both sides see the data, only the winner gets a hit.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q  <= 1'b0;
            own_d_q <= 1'b0;
        end else begin
            busy_q  <= (mem_ren_o | mem_wen_o) & ~mem_ready_i;   // Access still waiting.
            own_d_q <= sel_d;
        end
    end

    a_one_access: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren_o && mem_wen_o));

endmodule

`default_nettype wire

// File: logic/pipeline_cpu.sv
/* Single memory port shared by fetch and data. A request holds until mem_ready_i. */
`default_nettype none

module pipeline_cpu import cpu_types_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  word_t mem_rdata_i,
    input  logic  mem_ready_i,
    output word_t mem_addr_o,
    output word_t mem_wdata_o,
    output logic  mem_ren_o,
    output logic  mem_wen_o,
    output logic  halt_o
);
    logic       en, freeze, flush;
    logic       iren, ihit, dhit, ex_dren, ex_dwen;
    word_t      iaddr, rdata, daddr, dstore;
    logic       branch_taken, fd_valid;
    word_t      branch_target, fd_instr, fd_npc;
    logic       wb_wen;
    regbits_t   wb_sel;
    word_t      wb_data;
    word_t      de_rdat1, de_rdat2, de_imm;
    regbits_t   de_rd_sel;
    logic       de_reg_wr, de_alu_src, de_dren, de_dwen, de_branch, de_halt;
    aluop_t     de_alu_op;
    word_t      dx_npc, dx_rdat1, dx_rdat2, dx_imm;
    logic [4:0] dx_shamt;
    regbits_t   dx_rd_sel;
    logic       dx_reg_wr, dx_alu_src, dx_dren, dx_dwen, dx_branch, dx_halt;
    aluop_t     dx_alu_op;

    memory_arbiter u_memory_arbiter (
        .CLK, .nRST, .iren_i(iren), .iaddr_i(iaddr), .dren_i(ex_dren), .dwen_i(ex_dwen),
        .daddr_i(daddr), .dstore_i(dstore), .mem_rdata_i, .mem_ready_i, .ihit_o(ihit),
        .dhit_o(dhit), .rdata_o(rdata), .mem_addr_o, .mem_wdata_o, .mem_ren_o, .mem_wen_o);

    fetch_stage u_fetch_stage (
        .CLK, .nRST, .en_i(en), .flush_i(flush), .halt_i(halt_o),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target), .ihit_i(ihit),
        .rdata_i(rdata), .iren_o(iren), .iaddr_o(iaddr), .instr_o(fd_instr),
        .npc_o(fd_npc), .valid_o(fd_valid));

    decode_stage u_decode_stage (
        .CLK, .nRST, .instr_i(fd_instr), .npc_i(fd_npc), .wb_wen_i(wb_wen),
        .wb_sel_i(wb_sel), .wb_data_i(wb_data), .rdat1_o(de_rdat1), .rdat2_o(de_rdat2),
        .imm_o(de_imm), .rd_sel_o(de_rd_sel), .reg_wr_o(de_reg_wr), .alu_src_o(de_alu_src),
        .alu_op_o(de_alu_op), .dren_o(de_dren), .dwen_o(de_dwen), .branch_o(de_branch),
        .halt_o(de_halt));

    id_ex u_id_ex (
        .CLK, .nRST, .en_i(en), .freeze_i(freeze), .flush_i(flush),
        .npc_i(fd_npc), .rdat1_i(de_rdat1), .rdat2_i(de_rdat2), .imm_i(de_imm),
        .shamt_i(fd_instr[10:6]), .rd_sel_i(de_rd_sel), .reg_wr_i(de_reg_wr),
        .alu_src_i(de_alu_src), .alu_op_i(de_alu_op), .dren_i(de_dren), .dwen_i(de_dwen),
        .branch_i(de_branch), .halt_i(de_halt),
        .npc_o(dx_npc), .rdat1_o(dx_rdat1), .rdat2_o(dx_rdat2), .imm_o(dx_imm),
        .shamt_o(dx_shamt), .rd_sel_o(dx_rd_sel), .reg_wr_o(dx_reg_wr),
        .alu_src_o(dx_alu_src), .alu_op_o(dx_alu_op), .dren_o(dx_dren), .dwen_o(dx_dwen),
        .branch_o(dx_branch), .halt_o(dx_halt));

    execute_mem_stage u_execute_mem_stage (
        .CLK, .nRST, .en_i(en), .npc_i(dx_npc), .rdat1_i(dx_rdat1), .rdat2_i(dx_rdat2),
        .imm_i(dx_imm), .shamt_i(dx_shamt), .rd_sel_i(dx_rd_sel), .reg_wr_i(dx_reg_wr),
        .alu_src_i(dx_alu_src), .alu_op_i(dx_alu_op), .dren_i(dx_dren), .dwen_i(dx_dwen),
        .branch_i(dx_branch), .halt_i(dx_halt), .dhit_i(dhit), .rdata_i(rdata),
        .dren_o(ex_dren), .dwen_o(ex_dwen), .daddr_o(daddr), .dstore_o(dstore),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target), .halt_o,
        .wb_wen_o(wb_wen), .wb_sel_o(wb_sel), .wb_data_o(wb_data));

    hazard_unit u_hazard_unit (
        .dren_i(ex_dren), .dwen_i(ex_dwen), .dhit_i(dhit), .fetch_valid_i(fd_valid),
        .branch_taken_i(branch_taken), .en_o(en), .freeze_o(freeze), .flush_o(flush));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module cpu_tb -o cpu_tb_sim \
    && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
